// File: circular_queue.sv
`timescale 1ns/1ps
`default_nettype none

module circular_queue #(
    parameter type entry_t = logic,
    parameter int DEPTH = 8,
    localparam int PTR_W = $clog2(DEPTH),
    localparam int CNT_W = PTR_W + 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  entry_t           push_data,
    input  logic             pop,
    input  logic [DEPTH-1:0] upd_en,
    input  entry_t           upd_data [DEPTH],
    output entry_t           slots [DEPTH],
    output entry_t           head_data,
    output logic [PTR_W-1:0] push_ptr,
    output logic [PTR_W-1:0] pop_ptr,
    output logic             full,
    output logic             empty
);

    logic [CNT_W-1:0] count;

    // A push into a slot overrides an in-place update of that slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push && push_ptr == PTR_W'(i)) begin
                slots[i] <= push_data;
            end else if (upd_en[i]) begin
                slots[i] <= upd_data[i];
            end
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            push_ptr <= '0;
            pop_ptr  <= '0;
            count    <= '0;
        end else begin
            if (push) begin
                push_ptr <= push_ptr + 1'b1;
            end
            if (pop) begin
                pop_ptr <= pop_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    assign head_data = slots[pop_ptr];
    assign full      = (count == CNT_W'(DEPTH));
    assign empty     = (count == '0);

    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst)
        push |-> !full
    );

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        pop |-> !empty
    );

endmodule

`default_nettype wire

// File: load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align
    import lsq_pkg::*;
(
    input  logic        clk,
    input  logic        valid,
    input  logic [31:0] raw,
    input  logic [1:0]  offset,
    input  mem_size_t   size,
    input  logic        is_unsigned,
    output logic [31:0] data
);

    logic [31:0] shifted;

    // Bring the addressed byte lane down to bit 0
    assign shifted = raw >> {offset, 3'b000};

    always_comb begin
        case (size)
            size_byte: begin
                data = {{24{shifted[7] && !is_unsigned}}, shifted[7:0]};
            end
            size_half: begin
                data = {{16{shifted[15] && !is_unsigned}}, shifted[15:0]};
            end
            default: begin
                data = raw;
            end
        endcase
    end

    legal_offset: assert property (
        @(posedge clk)
        valid |-> (size != size_half || !offset[0]) &&
                  (size != size_word || offset == 2'b00)
    );

endmodule

`default_nettype wire

// File: load_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_queue
    import lsq_pkg::*;
#(
    parameter int DEPTH = 8,
    localparam int PTR_W = $clog2(DEPTH)
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              dispatch_valid,
    input  logic              dispatch_is_store,
    input  mem_size_t         dispatch_size,
    input  logic              dispatch_unsigned,
    input  logic [PREG_W-1:0] dispatch_rs1,
    input  logic              dispatch_rs1_ready,
    input  logic [PREG_W-1:0] dispatch_rs2,
    input  logic              dispatch_rs2_ready,
    input  logic [PREG_W-1:0] dispatch_rd,
    input  logic [31:0]       dispatch_imm,
    output logic              dispatch_ready,
    input  logic              wb_valid,
    input  logic [PREG_W-1:0] wb_tag,
    output logic [PREG_W-1:0] rd_tag_a,
    output logic [PREG_W-1:0] rd_tag_b,
    input  logic [31:0]       rd_value_a,
    input  logic [31:0]       rd_value_b,
    output logic [31:0]       dmem_addr,
    output logic [3:0]        dmem_rmask,
    output logic [3:0]        dmem_wmask,
    output logic [31:0]       dmem_wdata,
    input  logic [31:0]       dmem_rdata,
    input  logic              dmem_resp,
    output logic [1:0]        load_offset,
    output mem_size_t         load_size,
    output logic              load_unsigned,
    input  logic [31:0]       aligned_data,
    output logic              result_valid,
    output logic [PREG_W-1:0] result_tag,
    output logic [31:0]       result_value,
    output logic              store_done
);

    load_entry_t  ld_push_data, ld_head;
    load_entry_t  ld_slots [DEPTH];
    load_entry_t  ld_upd [DEPTH];
    store_entry_t st_push_data, st_head;
    store_entry_t st_slots [DEPTH];
    store_entry_t st_upd [DEPTH];
    logic [DEPTH-1:0] ld_upd_en, st_upd_en;
    logic [PTR_W-1:0] ld_push_ptr, ld_pop_ptr, st_push_ptr, st_pop_ptr;
    logic [PTR_W-1:0] ld_pop_next, st_pop_next;
    logic ld_full, ld_empty, st_full, st_empty;
    logic push_load, push_store, pop_load, pop_store;

    // Other queue's push pointer at dispatch, and whether it has been reached
    logic [PTR_W-1:0] ld_xptr [DEPTH];
    logic [PTR_W-1:0] st_xptr [DEPTH];
    logic [DEPTH-1:0] ld_xmet, st_xmet;

    lsq_state_t state, next_state;
    logic in_wait, ld_ready, st_ready, go_load, go_store;
    logic [31:0] issue_addr;
    mem_size_t issue_size;
    logic [31:0] addr_q, wdata_q;
    logic [3:0] mask_q;
    mem_size_t size_q;
    logic unsigned_q;
    logic [PREG_W-1:0] rd_q;

    function automatic logic woken(input logic [PREG_W-1:0] tag);
        woken = (wb_valid && wb_tag == tag) || (result_valid && result_tag == tag);
    endfunction

    function automatic logic [3:0] size_mask(input mem_size_t size);
        case (size)
            size_byte: size_mask = 4'b0001;
            size_half: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    endfunction

    assign dispatch_ready = dispatch_is_store ? !st_full : !ld_full;
    assign push_load      = dispatch_valid && dispatch_ready && !dispatch_is_store;
    assign push_store     = dispatch_valid && dispatch_ready && dispatch_is_store;
    assign pop_load       = (state == request_load) && dmem_resp;
    assign pop_store      = (state == request_store) && dmem_resp;
    assign ld_pop_next    = ld_pop_ptr + 1'b1;
    assign st_pop_next    = st_pop_ptr + 1'b1;

    // New entries also catch a broadcast in the cycle they arrive
    always_comb begin
        ld_push_data.rs1         = dispatch_rs1;
        ld_push_data.rd          = dispatch_rd;
        ld_push_data.imm         = dispatch_imm;
        ld_push_data.size        = dispatch_size;
        ld_push_data.is_unsigned = dispatch_unsigned;
        ld_push_data.rs1_met     = dispatch_rs1_ready || woken(dispatch_rs1);
        st_push_data.rs1         = dispatch_rs1;
        st_push_data.rs2         = dispatch_rs2;
        st_push_data.imm         = dispatch_imm;
        st_push_data.size        = dispatch_size;
        st_push_data.rs1_met     = dispatch_rs1_ready || woken(dispatch_rs1);
        st_push_data.rs2_met     = dispatch_rs2_ready || woken(dispatch_rs2);
    end

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            ld_upd[i]         = ld_slots[i];
            ld_upd[i].rs1_met = 1'b1;
            ld_upd_en[i]      = woken(ld_slots[i].rs1);
            st_upd[i]         = st_slots[i];
            st_upd[i].rs1_met = st_slots[i].rs1_met || woken(st_slots[i].rs1);
            st_upd[i].rs2_met = st_slots[i].rs2_met || woken(st_slots[i].rs2);
            st_upd_en[i]      = woken(st_slots[i].rs1) || woken(st_slots[i].rs2);
        end
    end

    circular_queue #(.entry_t(load_entry_t), .DEPTH(DEPTH)) load_q (
        .clk(clk), .rst(rst || flush),
        .push(push_load), .push_data(ld_push_data), .pop(pop_load),
        .upd_en(ld_upd_en), .upd_data(ld_upd),
        .slots(ld_slots), .head_data(ld_head),
        .push_ptr(ld_push_ptr), .pop_ptr(ld_pop_ptr),
        .full(ld_full), .empty(ld_empty)
    );

    circular_queue #(.entry_t(store_entry_t), .DEPTH(DEPTH)) store_q (
        .clk(clk), .rst(rst || flush),
        .push(push_store), .push_data(st_push_data), .pop(pop_store),
        .upd_en(st_upd_en), .upd_data(st_upd),
        .slots(st_slots), .head_data(st_head),
        .push_ptr(st_push_ptr), .pop_ptr(st_pop_ptr),
        .full(st_full), .empty(st_empty)
    );

    // Met is sticky, set when the other pop pointer steps onto the recorded value
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (push_load && ld_push_ptr == PTR_W'(i)) begin
                ld_xptr[i] <= st_push_ptr;
                ld_xmet[i] <= st_empty || (pop_store && st_pop_next == st_push_ptr);
            end else if (pop_store && st_pop_next == ld_xptr[i]) begin
                ld_xmet[i] <= 1'b1;
            end
            if (push_store && st_push_ptr == PTR_W'(i)) begin
                st_xptr[i] <= ld_push_ptr;
                st_xmet[i] <= ld_empty || (pop_load && ld_pop_next == ld_push_ptr);
            end else if (pop_load && ld_pop_next == st_xptr[i]) begin
                st_xmet[i] <= 1'b1;
            end
        end
    end

    assign ld_ready = !ld_empty && ld_head.rs1_met && ld_xmet[ld_pop_ptr];
    assign st_ready = !st_empty && st_head.rs1_met && st_head.rs2_met && st_xmet[st_pop_ptr];
    assign in_wait  = (state == wait_load_pri) || (state == wait_store_pri);
    assign go_load  = in_wait && ld_ready && (state == wait_load_pri || !st_ready);
    assign go_store = in_wait && st_ready && !go_load;

    always_comb begin
        next_state = state;
        case (state)
            wait_load_pri, wait_store_pri: begin
                if (go_load) begin
                    next_state = request_load;
                end else if (go_store) begin
                    next_state = request_store;
                end
            end
            request_load:  if (dmem_resp) next_state = finish_load;
            request_store: if (dmem_resp) next_state = finish_store;
            // Hand priority to the other kind after each access
            finish_load:   next_state = wait_store_pri;
            finish_store:  next_state = wait_load_pri;
            default:       next_state = wait_load_pri;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= wait_load_pri;
        end else begin
            state <= next_state;
        end
    end

    assign rd_tag_a   = go_store ? st_head.rs1 : ld_head.rs1;
    assign rd_tag_b   = st_head.rs2;
    assign issue_addr = rd_value_a + (go_store ? st_head.imm : ld_head.imm);
    assign issue_size = go_store ? st_head.size : ld_head.size;

    always_ff @(posedge clk) begin
        if (go_load || go_store) begin
            addr_q     <= issue_addr;
            size_q     <= issue_size;
            mask_q     <= size_mask(issue_size) << issue_addr[1:0];
            wdata_q    <= rd_value_b << {issue_addr[1:0], 3'b000};
            unsigned_q <= ld_head.is_unsigned;
            rd_q       <= ld_head.rd;
        end
        if (pop_load) begin
            result_value <= aligned_data;
        end
    end

    assign dmem_addr     = addr_q;
    assign dmem_wdata    = wdata_q;
    assign dmem_rmask    = (state == request_load) ? mask_q : 4'b0000;
    assign dmem_wmask    = (state == request_store) ? mask_q : 4'b0000;
    assign load_offset   = addr_q[1:0];
    assign load_size     = size_q;
    assign load_unsigned = unsigned_q;
    assign result_valid  = (state == finish_load);
    assign result_tag    = rd_q;
    assign store_done    = (state == finish_store);

    request_held_until_resp: assert property (
        @(posedge clk) disable iff (rst || flush)
        (dmem_rmask != 4'b0000 || dmem_wmask != 4'b0000) && !dmem_resp |=>
            $stable(dmem_addr) && $stable(dmem_rmask) &&
            $stable(dmem_wmask) && $stable(dmem_wdata)
    );

    request_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (dmem_rmask != 4'b0000 || dmem_wmask != 4'b0000) |->
            (size_q != size_half || !dmem_addr[0]) &&
            (size_q != size_word || dmem_addr[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

// File: lsq_pkg.sv
`default_nettype none

package lsq_pkg;

    localparam int NUM_PREGS = 64;
    localparam int PREG_W = 6;

    // Access width of a load or store
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef struct packed {
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rd;
        logic [31:0]       imm;
        mem_size_t         size;
        logic              is_unsigned;
        logic              rs1_met;
    } load_entry_t;

    // Store data comes from rs2, so there is no destination tag
    typedef struct packed {
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rs2;
        logic [31:0]       imm;
        mem_size_t         size;
        logic              rs1_met;
        logic              rs2_met;
    } store_entry_t;

    // Wait states carry the kind that wins when both heads are ready
    typedef enum logic [2:0] {
        wait_load_pri  = 3'd0,
        wait_store_pri = 3'd1,
        request_load   = 3'd2,
        request_store  = 3'd3,
        finish_load    = 3'd4,
        finish_store   = 3'd5
    } lsq_state_t;

endpackage

`default_nettype wire

// File: lsq_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsq_top
    import lsq_pkg::*;
#(
    parameter int DEPTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              dispatch_valid,
    input  logic              dispatch_is_store,
    input  mem_size_t         dispatch_size,
    input  logic              dispatch_unsigned,
    input  logic [PREG_W-1:0] dispatch_rs1,
    input  logic              dispatch_rs1_ready,
    input  logic [PREG_W-1:0] dispatch_rs2,
    input  logic              dispatch_rs2_ready,
    input  logic [PREG_W-1:0] dispatch_rd,
    input  logic [31:0]       dispatch_imm,
    output logic              dispatch_ready,
    input  logic              wb_valid,
    input  logic [PREG_W-1:0] wb_tag,
    input  logic [31:0]       wb_value,
    output logic              result_valid,
    output logic [PREG_W-1:0] result_tag,
    output logic [31:0]       result_value,
    output logic              store_done,
    output logic [31:0]       dmem_addr,
    output logic [3:0]        dmem_rmask,
    output logic [3:0]        dmem_wmask,
    output logic [31:0]       dmem_wdata,
    input  logic [31:0]       dmem_rdata,
    input  logic              dmem_resp
);

    logic [PREG_W-1:0] rd_tag_a, rd_tag_b;
    logic [31:0] rd_value_a, rd_value_b, aligned_data;
    logic [1:0] load_offset;
    mem_size_t load_size;
    logic load_unsigned;

    load_store_queue #(.DEPTH(DEPTH)) i_lsq (
        .clk(clk), .rst(rst), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch_is_store(dispatch_is_store),
        .dispatch_size(dispatch_size), .dispatch_unsigned(dispatch_unsigned),
        .dispatch_rs1(dispatch_rs1), .dispatch_rs1_ready(dispatch_rs1_ready),
        .dispatch_rs2(dispatch_rs2), .dispatch_rs2_ready(dispatch_rs2_ready),
        .dispatch_rd(dispatch_rd), .dispatch_imm(dispatch_imm),
        .dispatch_ready(dispatch_ready),
        .wb_valid(wb_valid), .wb_tag(wb_tag),
        .rd_tag_a(rd_tag_a), .rd_tag_b(rd_tag_b),
        .rd_value_a(rd_value_a), .rd_value_b(rd_value_b),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp),
        .load_offset(load_offset), .load_size(load_size),
        .load_unsigned(load_unsigned), .aligned_data(aligned_data),
        .result_valid(result_valid), .result_tag(result_tag),
        .result_value(result_value), .store_done(store_done)
    );

    // A nonzero read mask marks a load request on the port
    load_align i_align (
        .clk(clk), .valid(dmem_rmask != 4'b0000),
        .raw(dmem_rdata), .offset(load_offset), .size(load_size),
        .is_unsigned(load_unsigned), .data(aligned_data)
    );

    phys_regfile i_prf (
        .clk(clk), .rst(rst),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .result_valid(result_valid), .result_tag(result_tag),
        .result_value(result_value),
        .rd_tag_a(rd_tag_a), .rd_tag_b(rd_tag_b),
        .rd_value_a(rd_value_a), .rd_value_b(rd_value_b)
    );

endmodule

`default_nettype wire

// File: phys_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module phys_regfile
    import lsq_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              wb_valid,
    input  logic [PREG_W-1:0] wb_tag,
    input  logic [31:0]       wb_value,
    input  logic              result_valid,
    input  logic [PREG_W-1:0] result_tag,
    input  logic [31:0]       result_value,
    input  logic [PREG_W-1:0] rd_tag_a,
    input  logic [PREG_W-1:0] rd_tag_b,
    output logic [31:0]       rd_value_a,
    output logic [31:0]       rd_value_b
);

    logic [31:0] regs [NUM_PREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_valid) begin
                regs[wb_tag] <= wb_value;
            end
            if (result_valid) begin
                regs[result_tag] <= result_value;
            end
        end
    end

    // No bypass, an entry issues at least one cycle after its wakeup
    assign rd_value_a = regs[rd_tag_a];
    assign rd_value_b = regs[rd_tag_b];

    no_write_collision: assert property (
        @(posedge clk) disable iff (rst)
        wb_valid && result_valid |-> wb_tag != result_tag
    );

endmodule

`default_nettype wire

// File: tb.f
lsq_pkg.sv
circular_queue.sv
load_align.sv
phys_regfile.sv
load_store_queue.sv
lsq_top.sv
tb_lsq_top.sv

// File: tb_lsq_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsq_top;
    import lsq_pkg::*;

    localparam int DEPTH = 8;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic flush = 1'b0;
    logic dispatch_valid = 1'b0;
    logic dispatch_is_store = 1'b0;
    mem_size_t dispatch_size = size_word;
    logic dispatch_unsigned = 1'b0;
    logic [PREG_W-1:0] dispatch_rs1 = '0;
    logic dispatch_rs1_ready = 1'b0;
    logic [PREG_W-1:0] dispatch_rs2 = '0;
    logic dispatch_rs2_ready = 1'b0;
    logic [PREG_W-1:0] dispatch_rd = '0;
    logic [31:0] dispatch_imm = '0;
    logic dispatch_ready;
    logic wb_valid = 1'b0;
    logic [PREG_W-1:0] wb_tag = '0;
    logic [31:0] wb_value = '0;
    logic result_valid, store_done;
    logic [PREG_W-1:0] result_tag;
    logic [31:0] result_value, dmem_addr, dmem_wdata;
    logic [3:0] dmem_rmask, dmem_wmask;
    logic [31:0] dmem_rdata = '0;
    logic dmem_resp = 1'b0;

    integer seed = 92;
    int fail_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int issued = 0;
    int cycles = 0;
    int rd_next = 0;
    logic src_blocked = 1'b0;

    // Memory model and its reference copy
    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] ref_regs [NUM_PREGS];
    logic busy = 1'b0;
    int wait_cnt = 0;

    // Expected results and dmem accesses in program order
    logic [PREG_W-1:0] res_tag_q [$];
    logic [31:0] res_val_q [$];
    logic [31:0] acc_addr_q [$];
    logic [3:0] acc_rmask_q [$];
    logic [3:0] acc_wmask_q [$];
    logic [31:0] acc_wdata_q [$];
    int st_pending = 0;
    logic res_any = 1'b0;
    logic acc_any = 1'b0;
    logic [PREG_W-1:0] exp_tag = '0;
    logic [31:0] exp_value = '0;
    logic [31:0] exp_addr = '0;
    logic [3:0] exp_rmask = '0;
    logic [3:0] exp_wmask = '0;
    logic [31:0] exp_wdata = '0;

    lsq_top #(.DEPTH(DEPTH)) i_lsq_top (
        .clk(clk), .rst(rst), .flush(flush),
        .dispatch_valid(dispatch_valid), .dispatch_is_store(dispatch_is_store),
        .dispatch_size(dispatch_size), .dispatch_unsigned(dispatch_unsigned),
        .dispatch_rs1(dispatch_rs1), .dispatch_rs1_ready(dispatch_rs1_ready),
        .dispatch_rs2(dispatch_rs2), .dispatch_rs2_ready(dispatch_rs2_ready),
        .dispatch_rd(dispatch_rd), .dispatch_imm(dispatch_imm),
        .dispatch_ready(dispatch_ready),
        .wb_valid(wb_valid), .wb_tag(wb_tag), .wb_value(wb_value),
        .result_valid(result_valid), .result_tag(result_tag),
        .result_value(result_value), .store_done(store_done),
        .dmem_addr(dmem_addr), .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_resp(dmem_resp)
    );

    always #5 clk = ~clk;

    function automatic logic [3:0] lane_mask(input mem_size_t size, input logic [1:0] off);
        logic [3:0] m;
        m = (size == size_byte) ? 4'b0001 : (size == size_half) ? 4'b0011 : 4'b1111;
        return m << off;
    endfunction

    // Program-order replay of one accepted instruction
    task automatic replay_dispatch();
        logic [31:0] addr, word, data;
        logic [3:0] m;
        addr = ref_regs[dispatch_rs1] + dispatch_imm;
        m = lane_mask(dispatch_size, addr[1:0]);
        word = ref_mem[addr[9:2]];
        issued++;
        if (dispatch_is_store) begin
            data = ref_regs[dispatch_rs2] << (8 * addr[1:0]);
            for (int b = 0; b < 4; b++) begin
                if (m[b]) begin
                    word[8*b +: 8] = data[8*b +: 8];
                end
            end
            ref_mem[addr[9:2]] = word;
            st_pending++;
        end else begin
            data = word >> (8 * addr[1:0]);
            if (dispatch_size == size_byte) begin
                data = dispatch_unsigned ? {24'h0, data[7:0]} : {{24{data[7]}}, data[7:0]};
            end else if (dispatch_size == size_half) begin
                data = dispatch_unsigned ? {16'h0, data[15:0]} : {{16{data[15]}}, data[15:0]};
            end
            res_tag_q.push_back(dispatch_rd);
            res_val_q.push_back(data);
            data = '0;
        end
        acc_addr_q.push_back(addr);
        acc_rmask_q.push_back(dispatch_is_store ? 4'b0000 : m);
        acc_wmask_q.push_back(dispatch_is_store ? m : 4'b0000);
        acc_wdata_q.push_back(data);
    endtask

    always @(posedge clk) begin
        if (rst || flush) begin
            res_tag_q.delete();
            res_val_q.delete();
            acc_addr_q.delete();
            acc_rmask_q.delete();
            acc_wmask_q.delete();
            acc_wdata_q.delete();
            st_pending = 0;
        end else begin
            if (result_valid && res_tag_q.size() > 0) begin
                void'(res_tag_q.pop_front());
                void'(res_val_q.pop_front());
            end
            if (store_done && st_pending > 0) begin
                st_pending--;
            end
            if (dmem_resp && (dmem_rmask != 0 || dmem_wmask != 0) && acc_addr_q.size() > 0) begin
                void'(acc_addr_q.pop_front());
                void'(acc_rmask_q.pop_front());
                void'(acc_wmask_q.pop_front());
                void'(acc_wdata_q.pop_front());
            end
            if (dispatch_valid && dispatch_ready) begin
                replay_dispatch();
            end
        end
        res_any = res_tag_q.size() > 0;
        acc_any = acc_addr_q.size() > 0;
        exp_tag = res_any ? res_tag_q[0] : '0;
        exp_value = res_any ? res_val_q[0] : '0;
        exp_addr = acc_any ? acc_addr_q[0] : '0;
        exp_rmask = acc_any ? acc_rmask_q[0] : '0;
        exp_wmask = acc_any ? acc_wmask_q[0] : '0;
        exp_wdata = acc_any ? acc_wdata_q[0] : '0;
    end

    // Memory answers after 1 to 4 cycles and forgets a request that vanishes
    always @(posedge clk) begin
        #1;
        if (rst || dmem_resp) begin
            dmem_resp = 1'b0;
            busy = 1'b0;
        end else if (dmem_rmask != 0 || dmem_wmask != 0) begin
            if (!busy) begin
                busy = 1'b1;
                wait_cnt = $unsigned($random(seed)) % 4;
            end else begin
                wait_cnt--;
            end
            if (wait_cnt <= 0) begin
                dmem_rdata = mem[dmem_addr[9:2]];
                for (int b = 0; b < 4; b++) begin
                    if (dmem_wmask[b]) begin
                        mem[dmem_addr[9:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
                    end
                end
                dmem_resp = 1'b1;
            end
        end else begin
            busy = 1'b0;
        end
    end

    result_tag_ok: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> res_any && result_tag == exp_tag)
        else begin
            fail_count++;
            $display("CHECK FAILED result_tag exp %h got %h", $sampled(exp_tag),
                     $sampled(result_tag));
        end

    result_value_ok: assert property (@(posedge clk) disable iff (rst)
        result_valid |-> res_any && result_value == exp_value)
        else begin
            fail_count++;
            $display("CHECK FAILED result_value exp %h got %h", $sampled(exp_value),
                     $sampled(result_value));
        end

    store_done_ok: assert property (@(posedge clk) disable iff (rst)
        store_done |-> st_pending > 0)
        else begin
            fail_count++;
            $display("store_done pulsed with no store outstanding");
        end

    access_addr_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_resp && (dmem_rmask != 0 || dmem_wmask != 0) |-> acc_any && dmem_addr == exp_addr)
        else begin
            fail_count++;
            $display("CHECK FAILED dmem_addr exp %h got %h", $sampled(exp_addr),
                     $sampled(dmem_addr));
        end

    access_mask_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_resp && (dmem_rmask != 0 || dmem_wmask != 0) |->
            dmem_rmask == exp_rmask && dmem_wmask == exp_wmask)
        else begin
            fail_count++;
            $display("CHECK FAILED dmem_rmask/dmem_wmask exp %h/%h got %h/%h",
                     $sampled(exp_rmask), $sampled(exp_wmask),
                     $sampled(dmem_rmask), $sampled(dmem_wmask));
        end

    access_wdata_ok: assert property (@(posedge clk) disable iff (rst)
        dmem_resp && dmem_wmask != 0 |-> dmem_wdata == exp_wdata)
        else begin
            fail_count++;
            $display("CHECK FAILED dmem_wdata exp %h got %h", $sampled(exp_wdata),
                     $sampled(dmem_wdata));
        end

    no_early_request: assert property (@(posedge clk) disable iff (rst)
        (dmem_rmask != 0 || dmem_wmask != 0) |-> !src_blocked)
        else begin
            fail_count++;
            $display("a load issued before its source register was written back");
        end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 200 * (issued + 1)) begin
            $display("timeout, the DUT stopped making progress");
            $display("sim failed");
            $finish;
        end
    end

    task automatic send_wb(input logic [PREG_W-1:0] tag, input logic [31:0] value);
        ref_regs[tag] = value;
        wb_valid = 1'b1;
        wb_tag = tag;
        wb_value = value;
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic issue(input logic is_store, input mem_size_t size, input logic uns,
                         input logic [PREG_W-1:0] rs1, input logic rs1_rdy,
                         input logic [PREG_W-1:0] rs2, input logic [31:0] imm);
        dispatch_is_store = is_store;
        dispatch_size = size;
        dispatch_unsigned = uns;
        dispatch_rs1 = rs1;
        dispatch_rs1_ready = rs1_rdy;
        dispatch_rs2 = rs2;
        dispatch_rs2_ready = 1'b1;
        dispatch_rd = PREG_W'(32 + rd_next % 32);
        dispatch_imm = imm;
        dispatch_valid = 1'b1;
        rd_next++;
        while (!dispatch_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        dispatch_valid = 1'b0;
    endtask

    // Immediate that reaches a random word of the modeled memory from register rs1
    function automatic logic [31:0] imm_for(input logic [PREG_W-1:0] rs1, input logic [1:0] off);
        logic [31:0] target;
        target = ($unsigned($random(seed)) % 256) * 4 + off;
        return target - ref_regs[rs1];
    endfunction

    task automatic drain();
        while (res_any || acc_any || st_pending > 0 || dmem_rmask != 0 || dmem_wmask != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (fail_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, fail_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        logic [1:0] off;
        for (int i = 0; i < 256; i++) begin
            mem[i] = i * 32'h9e3779b9 + 32'h01234567;
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < NUM_PREGS; i++) begin
            ref_regs[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = fail_count;
        for (int t = 1; t <= 12; t++) begin
            send_wb(PREG_W'(t), ($unsigned($random(seed)) % 256) * 4);
        end
        for (int n = 0; n < 10; n++) begin
            logic [PREG_W-1:0] r;
            r = PREG_W'(1 + n % 8);
            issue(1'b0, size_word, 1'b0, r, 1'b1, '0, imm_for(r, 2'd0));
        end
        drain();
        finish_test("word_loads", errs);

        errs = fail_count;
        for (int u = 0; u < 2; u++) begin
            for (int o = 0; o < 4; o++) begin
                issue(1'b0, size_byte, u[0], 3, 1'b1, '0, imm_for(3, o[1:0]));
                if (o % 2 == 0) begin
                    issue(1'b0, size_half, u[0], 4, 1'b1, '0, imm_for(4, o[1:0]));
                end
            end
        end
        drain();
        finish_test("byte_half_loads", errs);

        errs = fail_count;
        for (int n = 0; n < 8; n++) begin
            mem_size_t sz;
            logic [31:0] imm;
            sz = mem_size_t'(n % 3);
            off = (sz == size_word) ? 2'd0 : (sz == size_half) ? 2'd2 * n[0] : n[1:0];
            imm = imm_for(5, off);
            issue(1'b1, sz, 1'b0, 5, 1'b1, PREG_W'(9 + n % 4), imm);
            issue(1'b0, size_word, 1'b0, 5, 1'b1, '0, {imm[31:2], 2'b00});
            issue(1'b0, sz, n[1], 5, 1'b1, '0, imm);
        end
        drain();
        for (int i = 0; i < 256; i++) begin
            assert (mem[i] == ref_mem[i]) else begin
                fail_count++;
                $display("CHECK FAILED mem[%0d] exp %h got %h", i, ref_mem[i], mem[i]);
            end
        end
        finish_test("store_then_load", errs);

        errs = fail_count;
        ref_regs[16] = 32'd128;
        src_blocked = 1'b1;
        issue(1'b0, size_word, 1'b0, 16, 1'b0, '0, imm_for(16, 2'd0));
        repeat (10) @(posedge clk);
        #1;
        src_blocked = 1'b0;
        send_wb(16, 32'd128);
        drain();
        finish_test("wakeup", errs);

        errs = fail_count;
        ref_regs[20] = 32'd256;
        for (int n = 0; n < DEPTH; n++) begin
            issue(1'b0, size_word, 1'b0, 20, 1'b0, '0, imm_for(20, 2'd0));
        end
        dispatch_is_store = 1'b0;
        #0;
        assert (!dispatch_ready) else begin
            fail_count++;
            $display("dispatch_ready stayed high with the load queue full");
        end
        send_wb(20, 32'd256);
        drain();
        assert (dispatch_ready) else begin
            fail_count++;
            $display("dispatch_ready stayed low after the load queue drained");
        end
        finish_test("back_pressure", errs);

        errs = fail_count;
        ref_regs[24] = 32'd64;
        // A full load queue makes the ready check after the flush meaningful
        for (int n = 0; n < DEPTH; n++) begin
            issue(1'b0, size_word, 1'b0, 24, 1'b0, '0, imm_for(24, 2'd0));
        end
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        assert (dispatch_ready) else begin
            fail_count++;
            $display("dispatch_ready low after flush");
        end
        send_wb(24, 32'd64);
        repeat (20) @(posedge clk);
        #1;
        finish_test("flush", errs);

        $display("tests passed %0d failed %0d, check errors %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
